// File: testbench/cache_tests.txt
# columns: op addr wdata expected_rdata traffic, all hex
# op 0 read 1 write; traffic 0 hit, 1 clean miss, 2 dirty miss; rdata ignored on writes
0 0004 0000 5a5e 1
0 0006 0000 5a5c 0
1 0005 1234 0000 0
0 0005 0000 1234 0
0 0007 0000 5a5d 0
1 0048 abcd 0000 1
0 0048 0000 abcd 0
0 0049 0000 5a13 0
0 0024 0000 5a7e 2
0 0005 0000 1234 1
0 0025 0000 5a7f 1
0 0068 0000 5a32 2
0 0048 0000 abcd 1
1 1000 beef 0000 1
1 1001 cafe 0000 0
0 1000 0000 beef 0
0 1001 0000 cafe 0
1 2003 0f0f 0000 2
0 1001 0000 cafe 2
0 2003 0000 0f0f 1
0 1000 0000 beef 1
1 ffff 7777 0000 1
0 fffc 0000 a5a6 0
0 ffff 0000 7777 0
0 001c 0000 5a46 2
0 ffff 0000 7777 1
1 0030 5555 0000 1
1 0031 6666 0000 0
0 0030 0000 5555 0
0 0031 0000 6666 0
0 0010 0000 5a4a 2
0 0030 0000 5555 1

// File: build.f
design/cache_pkg.sv
design/cache_tag_mem.sv
design/cache_data_mem.sv
design/cache_controller.sv
design/cache_top.sv
testbench/cache_properties.sv
testbench/cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cache_tb -f build.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "result: pass"
else
  echo "result: fail"
  exit 1
fi

// File: testbench/cache_tb.sv
/* data cache testbench */

`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
();

  localparam int clk_period      = 4;
  localparam int reset_cycles    = 10;
  localparam int cycles_per_test = 40;                          // budget per request
  localparam int mem_depth       = 1 << (addr_width - offset_bits);  // lines in memory

  logic    clk;
  logic    rst;
  logic    cpu_req_valid;
  cpu_op_e cpu_req_op;
  addr_t   cpu_req_addr;
  word_t   cpu_req_data;
  logic    cpu_ready;
  word_t   cpu_rdata;
  logic    mem_req_valid;
  mem_op_e mem_req_op;
  addr_t   mem_req_addr;
  line_t   mem_req_data;
  logic    mem_ready;
  line_t   mem_rdata;

  cpu_op_e     test_op[$];
  addr_t       test_addr[$];
  word_t       test_wdata[$];
  word_t       test_rdata[$];
  logic [1:0]  test_kind[$];        // 0 hit, 1 clean miss, 2 dirty miss
  bit          tests_loaded = 1'b0;
  int          errors = 0;
  int          passed = 0;
  line_t       mem_lines [mem_depth];
  logic [31:0] lcg_state = 32'h05971008;
  int          wb_count;            // per test
  int          fetch_count;
  bit          busy = 1'b0;         // memory request in flight
  int          countdown;
  mem_op_e     pend_op;
  addr_t       pend_addr;
  line_t       pend_data;

  cache_top u_dut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t initial_word(input addr_t a);
    return a ^ 16'h5a5a;             // memory fill rule
  endfunction

  task automatic load_tests();
    int         fd;
    int         n;
    string      text;
    logic [3:0] op;
    logic [15:0] addr;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic [3:0] kind;
    fd = $fopen("testbench/cache_tests.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open testbench/cache_tests.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() > 0 && text[0] != "#") begin  // skip column notes
        n = $sscanf(text, "%h %h %h %h %h", op, addr, wdata, rdata, kind);
        if (n == 5) begin
          test_op.push_back(cpu_op_e'(op[0]));
          test_addr.push_back(addr);
          test_wdata.push_back(wdata);
          test_rdata.push_back(rdata);
          test_kind.push_back(kind[1:0]);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic check_traffic(input logic [1:0] kind, input int wbs, input int fetches,
                               input int lat);
    int exp_wb;
    int exp_fetch;
    exp_wb    = (kind == 2'd2) ? 1 : 0;   // only a dirty victim is written back
    exp_fetch = (kind == 2'd0) ? 0 : 1;   // every miss fetches one line
    if (wbs != exp_wb) begin
      $display("mismatch write_backs: got %h, expected %h", wbs, exp_wb);
      errors++;
    end
    if (fetches != exp_fetch) begin
      $display("mismatch fetches: got %h, expected %h", fetches, exp_fetch);
      errors++;
    end
    if (kind == 2'd0 && lat != 1) begin
      $display("mismatch hit_latency: got %h, expected %h", lat, 1);
      errors++;
    end
  endtask

  task automatic run_request(input int n);
    int lat;
    int err_before;
    bit done;
    err_before  = errors;
    wb_count    = 0;
    fetch_count = 0;
    @(posedge clk);
    #1;
    cpu_req_valid = 1'b1;
    cpu_req_op    = test_op[n];
    cpu_req_addr  = test_addr[n];
    cpu_req_data  = test_wdata[n];
    lat  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);                     // mid-cycle sample
      if (cpu_ready) done = 1'b1;
      else lat++;
    end
    if (test_op[n] == op_read) check_word("cpu_rdata", cpu_rdata, test_rdata[n]);
    @(posedge clk);
    #1;
    cpu_req_valid = 1'b0;
    check_traffic(test_kind[n], wb_count, fetch_count, lat);
    if (errors == err_before) passed++;
    $display("test %0d %s addr %h: %s", n, test_op[n].name(), test_addr[n],
             (errors == err_before) ? "ok" : "error");
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // behavioural memory answering in 1 to 4 cycles
  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    for (int i = 0; i < mem_depth; i++) begin
      for (int w = 0; w < 4; w++) begin
        mem_lines[i][w*word_width +: word_width] = initial_word(addr_t'(i * 4 + w));
      end
    end
    forever begin
      @(negedge clk);
      if (!rst && mem_req_valid === 1'b1) begin
        if (busy) begin
          $display("error: memory request issued while another is outstanding");
          errors++;
        end
        if (mem_req_addr[1:0] != 2'b00) begin
          $display("error: memory request address is not line aligned");
          errors++;
        end
        busy      = 1'b1;
        pend_op   = mem_req_op;
        pend_addr = mem_req_addr;
        pend_data = mem_req_data;
        lcg_state = lcg_next(lcg_state);
        countdown = 1 + int'(lcg_state[17:16]);
        if (mem_req_op == mem_write) wb_count++;
        else fetch_count++;
      end
      @(posedge clk);
      #1;
      mem_ready = 1'b0;
      if (busy) begin
        countdown--;
        if (countdown == 0) begin
          mem_ready = 1'b1;               // single-cycle answer
          busy      = 1'b0;
          if (pend_op == mem_write) mem_lines[pend_addr[15:2]] = pend_data;
          else mem_rdata = mem_lines[pend_addr[15:2]];
        end
      end
    end
  end

  initial begin
    rst           = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req_op    = op_read;
    cpu_req_addr  = '0;
    cpu_req_data  = '0;
    load_tests();
    tests_loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int n = 0; n < test_op.size(); n++) run_request(n);
    repeat (2) @(posedge clk);
    if (u_dut.u_props.fail_count != 0) begin
      $display("error: %0d handshake assertions failed", u_dut.u_props.fail_count);
      errors += u_dut.u_props.fail_count;
    end
    $display("tests run %0d, passed %0d, errors %0d", test_op.size(), passed, errors);
    if (errors == 0 && test_op.size() > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (tests_loaded);
    #((test_op.size() * cycles_per_test + reset_cycles) * clk_period);
    $display("timeout: the requests did not complete within the time budget");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: testbench/cache_properties.sv
/* cache handshake assertions */

`timescale 1ns/1ps

module cache_properties
  import cache_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    cpu_req_valid,
  input logic    cpu_ready,
  input logic    mem_req_valid,
  input mem_op_e mem_req_op,
  input logic    mem_ready
);

  logic outstanding;     // memory request awaiting mem_ready
  int   fail_count = 0;  // assertions failed so far

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
    end else if (mem_req_valid) begin
      outstanding <= 1'b1;   // also holds for the fetch issued on a write-back ack
    end else if (mem_ready) begin
      outstanding <= 1'b0;
    end
  end

  // only the fetch right after a write-back ack may overlap
  a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    (mem_req_valid && outstanding) |-> (mem_ready && mem_req_op == mem_read))
    else begin
      fail_count++;
      $error("memory request issued while another was outstanding");
    end

  a_ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
    cpu_ready |-> cpu_req_valid)
    else begin
      fail_count++;
      $error("cpu_ready high without cpu_req_valid");
    end

  a_quiet_after_reset: assert property (@(posedge clk)
    rst |=> (!cpu_ready && !mem_req_valid))
    else begin
      fail_count++;
      $error("cpu_ready or mem_req_valid high right after reset");
    end

endmodule

bind cache_top cache_properties u_props (
  .clk           (clk),
  .rst           (rst),
  .cpu_req_valid (cpu_req_valid),
  .cpu_ready     (cpu_ready),
  .mem_req_valid (mem_req_valid),
  .mem_req_op    (mem_req_op),
  .mem_ready     (mem_ready)
);

// File: design/cache_top.sv
/* data cache top */

`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    cpu_req_valid,
  input  cpu_op_e cpu_req_op,
  input  addr_t   cpu_req_addr,
  input  word_t   cpu_req_data,
  output logic    cpu_ready,
  output word_t   cpu_rdata,
  output logic    mem_req_valid,
  output mem_op_e mem_req_op,
  output addr_t   mem_req_addr,
  output line_t   mem_req_data,
  input  logic    mem_ready,
  input  line_t   mem_rdata
);

  // controller to tag store
  logic   tag_we;
  index_t tag_index;
  tag_t   tag_wtag;
  logic   tag_wdirty;
  tag_t   rd_tag;
  logic   rd_valid;
  logic   rd_dirty;

  // controller to data store
  logic   data_we;
  index_t data_index;
  line_t  data_wline;
  line_t  data_rline;

  cache_controller u_ctrl (.*);  // names match one to one

  cache_tag_mem u_tags (
    .clk      (clk),
    .rst      (rst),
    .we       (tag_we),
    .index    (tag_index),
    .wtag     (tag_wtag),
    .wdirty   (tag_wdirty),
    .rd_tag   (rd_tag),
    .rd_valid (rd_valid),
    .rd_dirty (rd_dirty)
  );

  cache_data_mem u_data (
    .clk   (clk),
    .we    (data_we),
    .index (data_index),
    .wline (data_wline),
    .rline (data_rline)
  );

endmodule

// File: design/cache_controller.sv
/* blocking write-back cache FSM */

`timescale 1ns/1ps

module cache_controller
  import cache_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  // cpu side
  input  logic    cpu_req_valid,
  input  cpu_op_e cpu_req_op,
  input  addr_t   cpu_req_addr,
  input  word_t   cpu_req_data,
  output logic    cpu_ready,
  output word_t   cpu_rdata,
  // memory side
  output logic    mem_req_valid,
  output mem_op_e mem_req_op,
  output addr_t   mem_req_addr,
  output line_t   mem_req_data,
  input  logic    mem_ready,
  input  line_t   mem_rdata,
  // tag store
  output logic    tag_we,
  output index_t  tag_index,
  output tag_t    tag_wtag,
  output logic    tag_wdirty,
  input  tag_t    rd_tag,
  input  logic    rd_valid,
  input  logic    rd_dirty,
  // data store
  output logic    data_we,
  output index_t  data_index,
  output line_t   data_wline,
  input  line_t   data_rline
);

  cache_state_e state, state_nxt;

  tag_t                   req_tag;   // tag of current request
  index_t                 req_index; // line of current request
  logic [offset_bits-1:0] req_word;  // word within line
  logic                   hit;
  logic                   is_write;
  line_t                  merged;    // line with cpu word inserted

  // address split
  assign req_tag   = cpu_req_addr[tag_msb:tag_lsb];
  assign req_index = cpu_req_addr[tag_lsb-1:offset_bits];
  assign req_word  = cpu_req_addr[offset_bits-1:0];

  assign hit      = rd_valid && (rd_tag == req_tag);
  assign is_write = (cpu_req_op == op_write);

  // both stores always look at the request line
  assign tag_index  = req_index;
  assign data_index = req_index;

  // word select and merge
  always_comb begin
    merged = data_rline;
    merged[req_word*word_width +: word_width] = cpu_req_data;
  end

  assign cpu_rdata    = data_rline[req_word*word_width +: word_width];
  assign mem_req_data = data_rline;  // only used for write-back

  always_comb begin
    state_nxt     = state;           // hold by default
    cpu_ready     = 1'b0;
    mem_req_valid = 1'b0;
    mem_req_op    = mem_read;
    mem_req_addr  = {cpu_req_addr[tag_msb:offset_bits], {offset_bits{1'b0}}};  // line aligned
    tag_we        = 1'b0;
    tag_wtag      = req_tag;
    tag_wdirty    = 1'b0;
    data_we       = 1'b0;
    data_wline    = merged;

    case (state)
      st_idle: begin
        if (cpu_req_valid) state_nxt = st_compare;  // latch into lookup
      end

      st_compare: begin
        if (hit) begin
          cpu_ready = 1'b1;          // done this cycle
          if (is_write) begin
            tag_we     = 1'b1;       // keep tag, mark dirty
            tag_wdirty = 1'b1;
            data_we    = 1'b1;       // store merged line
          end
          state_nxt = st_idle;
        end else begin
          mem_req_valid = 1'b1;      // single pulse as the state moves on
          if (rd_valid && rd_dirty) begin
            // evict old line first
            mem_req_op   = mem_write;
            mem_req_addr = {rd_tag, req_index, {offset_bits{1'b0}}};
            state_nxt    = st_write_back;
          end else begin
            state_nxt = st_allocate; // empty or clean victim
          end
        end
      end

      st_allocate: begin
        if (mem_ready) begin
          data_wline = mem_rdata;    // whole line from memory
          data_we    = 1'b1;
          tag_we     = 1'b1;
          tag_wdirty = is_write;     // write merges on re-compare
          state_nxt  = st_compare;
        end
      end

      st_write_back: begin
        if (mem_ready) begin
          mem_req_valid = 1'b1;      // fetch right after eviction ack
          state_nxt     = st_allocate;
        end
      end

      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// File: design/cache_data_mem.sv
/* cache line storage */

`timescale 1ns/1ps

module cache_data_mem
  import cache_pkg::*;
(
  input  logic   clk,
  input  logic   we,      // line write strobe
  input  index_t index,   // line select
  input  line_t  wline,   // full line in
  output line_t  rline    // full line out
);

  line_t lines [num_lines];  // one entry per cache line

  // whole-line write
  always_ff @(posedge clk) begin
    if (we) begin
      lines[index] <= wline;
    end
  end

  // async read at current index
  assign rline = lines[index];

endmodule

// File: design/cache_tag_mem.sv
/* tag, valid and dirty store */

`timescale 1ns/1ps

module cache_tag_mem
  import cache_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   we,       // write strobe
  input  index_t index,    // shared read/write index
  input  tag_t   wtag,
  input  logic   wdirty,
  output tag_t   rd_tag,
  output logic   rd_valid,
  output logic   rd_dirty
);

  tag_t tags  [num_lines];      // tag payload
  logic valid [num_lines];      // line holds data
  logic dirty [num_lines];      // line differs from memory

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_lines; i++) begin
        valid[i] <= 1'b0;       // all lines empty
        dirty[i] <= 1'b0;
      end
    end else if (we) begin
      valid[index] <= 1'b1;     // any tag write fills the line
      dirty[index] <= wdirty;
    end
  end

  always_ff @(posedge clk) begin
    if (we) tags[index] <= wtag;  // tag of the line now held
  end

  // combinational lookup
  assign rd_tag   = tags[index];
  assign rd_valid = valid[index];
  assign rd_dirty = dirty[index];

endmodule

// File: design/cache_pkg.sv
/* direct-mapped cache definitions */

package cache_pkg;

  // geometry
  localparam int addr_width  = 16;                      // cpu word address
  localparam int word_width  = 16;                      // one cpu word
  localparam int line_width  = 64;                      // four words per line
  localparam int num_lines   = 8;                       // direct mapped
  localparam int offset_bits = 2;                       // word within line
  localparam int index_bits  = 3;                       // line select
  localparam int tag_bits    = 11;                      // remaining upper bits
  localparam int tag_lsb     = offset_bits + index_bits; // bit 5
  localparam int tag_msb     = addr_width - 1;          // bit 15

  // field types
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [word_width-1:0] word_t;
  typedef logic [line_width-1:0] line_t;               // word 0 in low bits
  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [index_bits-1:0] index_t;

  // cpu request kind
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cpu_op_e;

  // memory request kind
  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  // controller states
  typedef enum logic [1:0] {
    st_idle       = 2'd0,
    st_compare    = 2'd1,
    st_allocate   = 2'd2,
    st_write_back = 2'd3
  } cache_state_e;

endpackage
